// ==== design/cmd_selector.sv ====
// ----------------------------------------------------------
// Command phase opcode selection
// Picks the PSRAM opcode for a special instruction or a host
// transfer and registers it with a one-cycle load strobe
// ----------------------------------------------------------

`timescale 1ns/1ps

module cmd_selector
(
   input  logic                     mem_clk,
   input  logic                     rst_n,
   // Host transfer request
   input  logic                     mem_mr_xfer_valid,
   input  logic                     mem_mr_xfer_wr_rd,
   input  psram_cmd_pkg::xfer_err_t mem_mr_error,
   input  psram_cmd_pkg::btype_t    mem_mr_xfer_btype,
   // Special instruction pulses
   input  logic                     spl_dpd_entry_valid,
   input  logic                     spl_hs_entry_valid,
   input  logic                     spl_global_reset_valid,
   // Opcodes from the CSR block
   input  logic                     mr_access,
   input  psram_cmd_pkg::cmd_t      linear_burst_wr,
   input  psram_cmd_pkg::cmd_t      linear_burst_rd,
   input  psram_cmd_pkg::cmd_t      sync_wr,
   input  psram_cmd_pkg::cmd_t      sync_rd,
   input  psram_cmd_pkg::cmd_t      global_reset_cmd,
   input  psram_cmd_pkg::cmd_t      mode_reg_wr,
   input  psram_cmd_pkg::cmd_t      mode_reg_rd,
   // To the data shifter
   output psram_cmd_pkg::cmd_t      cmd,
   output logic                     cmd_load
);

   psram_cmd_pkg::cmd_t next_cmd;
   logic                xfer_ok;
   logic                is_wrap;
   logic                sel_fire;

   // Any error code drops the transfer
   assign xfer_ok  = mem_mr_xfer_valid && (mem_mr_error == '0);
   assign is_wrap  = (mem_mr_xfer_btype == psram_cmd_pkg::BTYPE_WRAP);
   assign sel_fire = spl_dpd_entry_valid || spl_hs_entry_valid ||
                     spl_global_reset_valid || xfer_ok;

   // ---------------------------------------------------------
   // Priority select
   // ---------------------------------------------------------
   always_comb
   begin
      next_cmd = cmd;
      if (spl_dpd_entry_valid || spl_hs_entry_valid)
      begin
         // DPD and HS entry both go through a mode register write
         next_cmd = mode_reg_wr;
      end
      else if (spl_global_reset_valid)
      begin
         next_cmd = global_reset_cmd;
      end
      else if (xfer_ok)
      begin
         if (mr_access)
         begin
            // Mode register, burst type ignored
            next_cmd = mem_mr_xfer_wr_rd ? mode_reg_wr : mode_reg_rd;
         end
         else if (mem_mr_xfer_wr_rd)
         begin
            next_cmd = is_wrap ? sync_wr : linear_burst_wr;
         end
         else
         begin
            next_cmd = is_wrap ? sync_rd : linear_burst_rd;
         end
      end
   end

   // Registered command and strobe
   always_ff @(posedge mem_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cmd      <= '0;
         cmd_load <= 1'b0;
      end
      else
      begin
         cmd      <= next_cmd;
         cmd_load <= sel_fire;
      end
   end

endmodule

// ==== design/data_shifter.sv ====
// ----------------------------------------------------------
// Serial command output onto the PSRAM data pin
// Loads the opcode on cmd_load, shifts it out MSB first for
// CMD_BITS cycles with chip enable low, then reports idle
// ----------------------------------------------------------

`timescale 1ns/1ps

module data_shifter
(
   input  logic                mem_clk,
   input  logic                rst_n,
   input  psram_cmd_pkg::cmd_t cmd,
   input  logic                cmd_load,
   output logic                mem_ce_n,
   output logic                mem_dq,
   output logic                shifter_idle
);

   psram_cmd_pkg::shift_state_t state;
   psram_cmd_pkg::shift_state_t next_state;
   psram_cmd_pkg::cmd_t         shift_reg;
   psram_cmd_pkg::bit_cnt_t     bit_cnt;
   logic                        last_bit;
   logic                        start;

   assign start    = (state == psram_cmd_pkg::IDLE) && cmd_load;
   assign last_bit = (bit_cnt == psram_cmd_pkg::bit_cnt_t'(psram_cmd_pkg::CMD_BITS - 1));

   // ---------------------------------------------------------
   // FSM
   // ---------------------------------------------------------
   always_comb
   begin
      next_state = state;
      case (state)
         psram_cmd_pkg::IDLE:
         begin
            // Load while busy never reaches here
            if (cmd_load)
               next_state = psram_cmd_pkg::SHIFT;
         end
         psram_cmd_pkg::SHIFT:
         begin
            if (last_bit)
               next_state = psram_cmd_pkg::IDLE;
         end
         default: next_state = psram_cmd_pkg::IDLE;
      endcase
   end

   always_ff @(posedge mem_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state   <= psram_cmd_pkg::IDLE;
         bit_cnt <= '0;
      end
      else
      begin
         state <= next_state;
         // Counts serial cycles within SHIFT
         if (start || last_bit)
            bit_cnt <= '0;
         else if (state == psram_cmd_pkg::SHIFT)
            bit_cnt <= bit_cnt + 1'b1;
      end
   end

   // Shift register, MSB leaves first
   always_ff @(posedge mem_clk)
   begin
      if (start)
         shift_reg <= cmd;
      else if (state == psram_cmd_pkg::SHIFT)
         shift_reg <= {shift_reg[psram_cmd_pkg::CMD_BITS-2:0], 1'b0};
   end

   // Pin drive, pin parked low outside a command
   assign shifter_idle = (state == psram_cmd_pkg::IDLE);
   assign mem_ce_n     = shifter_idle;
   assign mem_dq       = !shifter_idle && shift_reg[psram_cmd_pkg::CMD_BITS-1];

endmodule

// ==== design/psram_cmd_pkg.sv ====
// ----------------------------------------------------------
// Shared types and constants for the PSRAM command phase
// Opcode widths, CSR map, reset opcodes, burst encodings
// Referenced by scoped names from every design file
// ----------------------------------------------------------

package psram_cmd_pkg;

   // Opcode and command framing
   localparam int CMD_BITS = 8;
   localparam int CNT_W    = $clog2(CMD_BITS);

   typedef logic [CMD_BITS-1:0] cmd_t;
   typedef logic [CNT_W-1:0]    bit_cnt_t;
   typedef logic [1:0]          btype_t;
   typedef logic [1:0]          xfer_err_t;
   typedef logic [2:0]          csr_addr_t;

   // Burst type 2 picks the wrapped opcodes, all others are linear
   localparam btype_t BTYPE_WRAP = 2'd2;

   // ---------------------------------------------------------
   // CSR register map
   // ---------------------------------------------------------
   localparam csr_addr_t ADDR_LINEAR_WR  = 3'd0;
   localparam csr_addr_t ADDR_LINEAR_RD  = 3'd1;
   localparam csr_addr_t ADDR_SYNC_WR    = 3'd2;
   localparam csr_addr_t ADDR_SYNC_RD    = 3'd3;
   localparam csr_addr_t ADDR_GLOBAL_RST = 3'd4;
   localparam csr_addr_t ADDR_MODE_WR    = 3'd5;
   localparam csr_addr_t ADDR_MODE_RD    = 3'd6;
   localparam csr_addr_t ADDR_MR_ACCESS  = 3'd7;

   // Usual PSRAM opcodes loaded at reset
   localparam cmd_t DEF_LINEAR_WR  = 8'hA0;
   localparam cmd_t DEF_LINEAR_RD  = 8'h20;
   localparam cmd_t DEF_SYNC_WR    = 8'h80;
   localparam cmd_t DEF_SYNC_RD    = 8'h00;
   localparam cmd_t DEF_GLOBAL_RST = 8'hFF;
   localparam cmd_t DEF_MODE_WR    = 8'hC0;
   localparam cmd_t DEF_MODE_RD    = 8'h40;

   // Data shifter FSM
   typedef enum logic {IDLE, SHIFT} shift_state_t;

endpackage

// ==== design/psram_cmd_top.sv ====
// ----------------------------------------------------------
// PSRAM controller command phase, top level
// Connects CSR, special instruction handler, selector and
// data shifter; xfer_ready tells the host a command can start
// ----------------------------------------------------------

`timescale 1ns/1ps

module psram_cmd_top
(
   input  logic                      mem_clk,
   input  logic                      rst_n,
   // Host transfer strobes
   input  logic                      xfer_valid,
   input  psram_cmd_pkg::xfer_err_t  xfer_err,
   input  logic                      xfer_wr_rd,
   input  psram_cmd_pkg::btype_t     xfer_btype,
   // Special instruction requests
   input  logic                      dpd_req,
   input  logic                      hs_req,
   input  logic                      gr_req,
   // CSR write port
   input  logic                      csr_wr_en,
   input  psram_cmd_pkg::csr_addr_t  csr_addr,
   input  psram_cmd_pkg::cmd_t       csr_wdata,
   // Status and memory pins
   output logic                      xfer_ready,
   output logic                      mem_ce_n,
   output logic                      mem_dq
);

   // CSR opcodes
   psram_cmd_pkg::cmd_t linear_burst_wr;
   psram_cmd_pkg::cmd_t linear_burst_rd;
   psram_cmd_pkg::cmd_t sync_wr;
   psram_cmd_pkg::cmd_t sync_rd;
   psram_cmd_pkg::cmd_t global_reset_cmd;
   psram_cmd_pkg::cmd_t mode_reg_wr;
   psram_cmd_pkg::cmd_t mode_reg_rd;
   logic                mr_access;
   // Handler pulses
   logic                spl_dpd_entry_valid;
   logic                spl_hs_entry_valid;
   logic                spl_global_reset_valid;
   // Selector to shifter
   psram_cmd_pkg::cmd_t cmd;
   logic                cmd_load;
   logic                shifter_idle;

   assign xfer_ready = shifter_idle;

   psram_csr u_csr
   (
      .mem_clk          (mem_clk),
      .rst_n            (rst_n),
      .csr_wr_en        (csr_wr_en),
      .csr_addr         (csr_addr),
      .csr_wdata        (csr_wdata),
      .linear_burst_wr  (linear_burst_wr),
      .linear_burst_rd  (linear_burst_rd),
      .sync_wr          (sync_wr),
      .sync_rd          (sync_rd),
      .global_reset_cmd (global_reset_cmd),
      .mode_reg_wr      (mode_reg_wr),
      .mode_reg_rd      (mode_reg_rd),
      .mr_access        (mr_access)
   );

   spl_instrn_handlr u_spl
   (
      .mem_clk                (mem_clk),
      .rst_n                  (rst_n),
      .dpd_req                (dpd_req),
      .hs_req                 (hs_req),
      .gr_req                 (gr_req),
      .shifter_idle           (shifter_idle),
      .spl_dpd_entry_valid    (spl_dpd_entry_valid),
      .spl_hs_entry_valid     (spl_hs_entry_valid),
      .spl_global_reset_valid (spl_global_reset_valid)
   );

   cmd_selector u_sel
   (
      .mem_clk                (mem_clk),
      .rst_n                  (rst_n),
      .mem_mr_xfer_valid      (xfer_valid),
      .mem_mr_xfer_wr_rd      (xfer_wr_rd),
      .mem_mr_error           (xfer_err),
      .mem_mr_xfer_btype      (xfer_btype),
      .spl_dpd_entry_valid    (spl_dpd_entry_valid),
      .spl_hs_entry_valid     (spl_hs_entry_valid),
      .spl_global_reset_valid (spl_global_reset_valid),
      .mr_access              (mr_access),
      .linear_burst_wr        (linear_burst_wr),
      .linear_burst_rd        (linear_burst_rd),
      .sync_wr                (sync_wr),
      .sync_rd                (sync_rd),
      .global_reset_cmd       (global_reset_cmd),
      .mode_reg_wr            (mode_reg_wr),
      .mode_reg_rd            (mode_reg_rd),
      .cmd                    (cmd),
      .cmd_load               (cmd_load)
   );

   data_shifter u_shift
   (
      .mem_clk      (mem_clk),
      .rst_n        (rst_n),
      .cmd          (cmd),
      .cmd_load     (cmd_load),
      .mem_ce_n     (mem_ce_n),
      .mem_dq       (mem_dq),
      .shifter_idle (shifter_idle)
   );

endmodule

// ==== design/psram_csr.sv ====
// ----------------------------------------------------------
// Programmable PSRAM opcodes and the mode-register access flag
// Written through a single-cycle address/data strobe port
// Values reach the outside only via the selected command
// ----------------------------------------------------------

`timescale 1ns/1ps

module psram_csr
(
   input  logic                    mem_clk,
   input  logic                    rst_n,
   input  logic                    csr_wr_en,
   input  psram_cmd_pkg::csr_addr_t csr_addr,
   input  psram_cmd_pkg::cmd_t     csr_wdata,
   output psram_cmd_pkg::cmd_t     linear_burst_wr,
   output psram_cmd_pkg::cmd_t     linear_burst_rd,
   output psram_cmd_pkg::cmd_t     sync_wr,
   output psram_cmd_pkg::cmd_t     sync_rd,
   output psram_cmd_pkg::cmd_t     global_reset_cmd,
   output psram_cmd_pkg::cmd_t     mode_reg_wr,
   output psram_cmd_pkg::cmd_t     mode_reg_rd,
   output logic                    mr_access
);

   // Register file with one write per cycle
   always_ff @(posedge mem_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         linear_burst_wr  <= psram_cmd_pkg::DEF_LINEAR_WR;
         linear_burst_rd  <= psram_cmd_pkg::DEF_LINEAR_RD;
         sync_wr          <= psram_cmd_pkg::DEF_SYNC_WR;
         sync_rd          <= psram_cmd_pkg::DEF_SYNC_RD;
         global_reset_cmd <= psram_cmd_pkg::DEF_GLOBAL_RST;
         mode_reg_wr      <= psram_cmd_pkg::DEF_MODE_WR;
         mode_reg_rd      <= psram_cmd_pkg::DEF_MODE_RD;
         // Memory array access by default
         mr_access        <= 1'b0;
      end
      else if (csr_wr_en)
      begin
         // Address decode
         case (csr_addr)
            psram_cmd_pkg::ADDR_LINEAR_WR:  linear_burst_wr  <= csr_wdata;
            psram_cmd_pkg::ADDR_LINEAR_RD:  linear_burst_rd  <= csr_wdata;
            psram_cmd_pkg::ADDR_SYNC_WR:    sync_wr          <= csr_wdata;
            psram_cmd_pkg::ADDR_SYNC_RD:    sync_rd          <= csr_wdata;
            psram_cmd_pkg::ADDR_GLOBAL_RST: global_reset_cmd <= csr_wdata;
            psram_cmd_pkg::ADDR_MODE_WR:    mode_reg_wr      <= csr_wdata;
            psram_cmd_pkg::ADDR_MODE_RD:    mode_reg_rd      <= csr_wdata;
            // Only bit 0 is implemented here
            psram_cmd_pkg::ADDR_MR_ACCESS:  mr_access        <= csr_wdata[0];
         endcase
      end
   end

endmodule

// ==== design/spl_instrn_handlr.sv ====
// ----------------------------------------------------------
// Special instruction handler: DPD, half-sleep, global reset
// Latches request pulses, then issues one pulse at a time
// toward the command selector while the shifter is idle
// ----------------------------------------------------------

`timescale 1ns/1ps

module spl_instrn_handlr
(
   input  logic mem_clk,
   input  logic rst_n,
   input  logic dpd_req,
   input  logic hs_req,
   input  logic gr_req,
   input  logic shifter_idle,
   output logic spl_dpd_entry_valid,
   output logic spl_hs_entry_valid,
   output logic spl_global_reset_valid
);

   // Pending requests
   logic dpd_pend;
   logic hs_pend;
   logic gr_pend;
   // High in the cycle after any pulse, while cmd_load is in flight
   logic issued_q;
   logic issue_ok;

   assign issue_ok = shifter_idle && !issued_q;

   // Fixed priority, DPD first
   assign spl_dpd_entry_valid    = issue_ok && dpd_pend;
   assign spl_hs_entry_valid     = issue_ok && !dpd_pend && hs_pend;
   assign spl_global_reset_valid = issue_ok && !dpd_pend && !hs_pend && gr_pend;

   always_ff @(posedge mem_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         dpd_pend <= 1'b0;
         hs_pend  <= 1'b0;
         gr_pend  <= 1'b0;
         issued_q <= 1'b0;
      end
      else
      begin
         // A new request wins over the clear of its own kind
         dpd_pend <= (dpd_pend && !spl_dpd_entry_valid) || dpd_req;
         hs_pend  <= (hs_pend && !spl_hs_entry_valid) || hs_req;
         gr_pend  <= (gr_pend && !spl_global_reset_valid) || gr_req;
         issued_q <= spl_dpd_entry_valid || spl_hs_entry_valid ||
                     spl_global_reset_valid;
      end
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the command phase testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_psram_cmd \
   --Mdir obj_dir -o tb_psram_cmd

# Exit status of the model is ignored here, the log decides
./obj_dir/tb_psram_cmd > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
   exit 1
fi
grep -q "RESULT: PASS" sim.log

// ==== sim.f ====
design/psram_cmd_pkg.sv
design/psram_csr.sv
design/spl_instrn_handlr.sv
design/cmd_selector.sv
design/data_shifter.sv
design/psram_cmd_top.sv
verif/tb_clk_gen.sv
verif/tb_psram_cmd.sv

// ==== verif/psram_cmd_testdata.txt ====
# name kind f1 f2 f3 expected (hex fields, expected opcode or NONE)
# csr: f1 addr, f2 data | xfer: f1 wr_rd, f2 btype, f3 err | dpd: f1 also gr | next: follow-on
lin_wr_bt0     xfer 1 0  0 A0
lin_rd_bt1     xfer 0 1  0 20
wrap_wr        xfer 1 2  0 80
wrap_rd        xfer 0 2  0 00
lin_wr_bt3     xfer 1 3  0 A0
lin_rd_bt0     xfer 0 0  0 20
err1_wr        xfer 1 0  1 NONE
err2_rd        xfer 0 2  2 NONE
err3_wr        xfer 1 2  3 NONE
after_err      xfer 1 2  0 80
dpd_entry      dpd  0 0  0 C0
hs_entry       hs   0 0  0 C0
glob_rst       gr   0 0  0 FF
dpd_and_gr     dpd  1 0  0 C0
gr_after_dpd   next 0 0  0 FF
set_mr_acc     csr  7 1  0 NONE
mr_wr_wrap     xfer 1 2  0 C0
mr_rd_lin      xfer 0 1  0 40
mr_rd_wrap     xfer 0 2  0 40
clr_mr_acc     csr  7 0  0 NONE
prog_lin_wr    csr  0 5A 0 NONE
prog_glob_rst  csr  4 3C 0 NONE
new_lin_wr     xfer 1 0  0 5A
new_glob_rst   gr   0 0  0 3C
prog_mode_wr   csr  5 96 0 NONE
new_hs         hs   0 0  0 96

// ==== verif/tb_clk_gen.sv ====
// ----------------------------------------------------------
// Testbench clock and reset source
// mem_clk with a 20 ns period, rst_n low for 5 cycles
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_clk_gen
(
   output logic mem_clk,
   output logic rst_n
);

   initial
   begin
      mem_clk = 1'b0;
      rst_n   = 1'b0;
      // Release away from the rising edge
      repeat (5) @(negedge mem_clk);
      rst_n = 1'b1;
   end

   always #10 mem_clk = ~mem_clk;

endmodule

// ==== verif/tb_psram_cmd.sv ====
// ----------------------------------------------------------
// Testbench for the PSRAM command phase
// Reads vectors from the vector file, drives the DUT on the
// falling edge and checks each serial opcode frame
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_psram_cmd;

   localparam string VEC_FILE = "verif/psram_cmd_testdata.txt";

   logic                     mem_clk;
   logic                     rst_n;
   logic                     xfer_valid;
   psram_cmd_pkg::xfer_err_t xfer_err;
   logic                     xfer_wr_rd;
   psram_cmd_pkg::btype_t    xfer_btype;
   logic                     dpd_req;
   logic                     hs_req;
   logic                     gr_req;
   logic                     csr_wr_en;
   psram_cmd_pkg::csr_addr_t csr_addr;
   psram_cmd_pkg::cmd_t      csr_wdata;
   logic                     xfer_ready;
   logic                     mem_ce_n;
   logic                     mem_dq;

   // Vector table
   string      vec_name[$];
   string      vec_kind[$];
   logic [7:0] vec_f1[$];
   logic [7:0] vec_f2[$];
   logic [7:0] vec_f3[$];
   logic [7:0] vec_exp[$];
   bit         vec_has_exp[$];

   // Frames seen on the memory pins
   psram_cmd_pkg::cmd_t frame_byte[$];
   int                  frame_len[$];
   int                  frame_start[$];
   psram_cmd_pkg::cmd_t shift_in;
   int                  bit_count = 0;
   int                  start_cyc = 0;
   int                  cycles = 0;
   int                  cycle_limit = 100;
   int                  issue_cyc = 0;
   int                  last_start = 0;

   tb_clk_gen u_clk
   (
      .mem_clk (mem_clk),
      .rst_n   (rst_n)
   );

   psram_cmd_top dut
   (
      .mem_clk    (mem_clk),
      .rst_n      (rst_n),
      .xfer_valid (xfer_valid),
      .xfer_err   (xfer_err),
      .xfer_wr_rd (xfer_wr_rd),
      .xfer_btype (xfer_btype),
      .dpd_req    (dpd_req),
      .hs_req     (hs_req),
      .gr_req     (gr_req),
      .csr_wr_en  (csr_wr_en),
      .csr_addr   (csr_addr),
      .csr_wdata  (csr_wdata),
      .xfer_ready (xfer_ready),
      .mem_ce_n   (mem_ce_n),
      .mem_dq     (mem_dq)
   );

   task automatic stop_with_failure(input string msg);
      $display("%0s", msg);
      $display("RESULT: FAIL");
      $fatal(1, "first error, stopping");
   endtask

   // ---------------------------------------------------------
   // Pin monitor and watchdog
   // ---------------------------------------------------------
   // Sampled values are those from before the edge
   always @(posedge mem_clk)
   begin
      cycles = cycles + 1;
      if (cycles > cycle_limit)
         stop_with_failure($sformatf("timeout after %0d cycles", cycles));
      else if (rst_n)
      begin
         // Ready is high exactly while no command is on the pins
         assert (xfer_ready == mem_ce_n)
         else stop_with_failure($sformatf("mismatch ready_level expected %0b actual %0b",
                                          mem_ce_n, xfer_ready));
         if (!mem_ce_n)
         begin
            if (bit_count == 0)
               start_cyc = cycles;
            // MSB arrives first
            shift_in  = {shift_in[6:0], mem_dq};
            bit_count = bit_count + 1;
         end
         else if (bit_count != 0)
         begin
            // Chip enable back high ends the frame
            frame_byte.push_back(shift_in);
            frame_len.push_back(bit_count);
            frame_start.push_back(start_cyc);
            bit_count = 0;
         end
      end
   end

   task automatic load_vectors();
      int         fd;
      int         cnt;
      string      line;
      string      name;
      string      kind;
      string      exp_tok;
      logic [7:0] f1;
      logic [7:0] f2;
      logic [7:0] f3;
      logic [7:0] ev;
      fd = $fopen(VEC_FILE, "r");
      assert (fd != 0)
      else stop_with_failure("cannot open the test vector file");
      while ($fgets(line, fd) != 0)
      begin
         // Comment and blank lines
         if (line.len() < 2 || line.substr(0, 0) == "#")
            continue;
         cnt = $sscanf(line, "%s %s %h %h %h %s", name, kind, f1, f2, f3, exp_tok);
         assert (cnt == 6)
         else stop_with_failure($sformatf("badly formed vector line: %0s", line));
         ev = 8'h00;
         if (exp_tok != "NONE")
            cnt = $sscanf(exp_tok, "%h", ev);
         vec_name.push_back(name);
         vec_kind.push_back(kind);
         vec_f1.push_back(f1);
         vec_f2.push_back(f2);
         vec_f3.push_back(f3);
         vec_exp.push_back(ev);
         vec_has_exp.push_back(exp_tok != "NONE");
      end
      $fclose(fd);
   endtask

   // Input drivers for use on a falling edge
   task automatic write_csr(input logic [7:0] addr, input logic [7:0] data);
      csr_wr_en = 1'b1;
      csr_addr  = addr[2:0];
      csr_wdata = data;
      @(negedge mem_clk);
      csr_wr_en = 1'b0;
   endtask

   task automatic pulse_xfer(input logic wr, input logic [1:0] bt, input logic [1:0] err);
      xfer_valid = 1'b1;
      xfer_wr_rd = wr;
      xfer_btype = bt;
      xfer_err   = err;
      @(negedge mem_clk);
      xfer_valid = 1'b0;
      xfer_err   = 2'd0;
   endtask

   task automatic pulse_special(input logic dpd, input logic hs, input logic gr);
      dpd_req = dpd;
      hs_req  = hs;
      gr_req  = gr;
      @(negedge mem_clk);
      dpd_req = 1'b0;
      hs_req  = 1'b0;
      gr_req  = 1'b0;
   endtask

   // ---------------------------------------------------------
   // Response checks
   // ---------------------------------------------------------
   task automatic check_frame(input int idx, input int offs);
      psram_cmd_pkg::cmd_t got;
      int                  len;
      int                  st;
      while (frame_byte.size() == 0)
         @(negedge mem_clk);
      got = frame_byte.pop_front();
      len = frame_len.pop_front();
      st  = frame_start.pop_front();
      last_start = st;
      assert (len == psram_cmd_pkg::CMD_BITS)
      else stop_with_failure($sformatf("wrong chip-enable length in %0s: low for %0d cycles",
                                       vec_name[idx], len));
      assert (st == issue_cyc + offs)
      else stop_with_failure($sformatf("command in %0s started at cycle %0d, not %0d",
                                       vec_name[idx], st, issue_cyc + offs));
      assert (got == vec_exp[idx])
      else stop_with_failure($sformatf("mismatch %0s expected %02h actual %02h",
                                       vec_name[idx], vec_exp[idx], got));
   endtask

   task automatic check_quiet(input int idx);
      repeat (12) @(negedge mem_clk);
      assert (frame_byte.size() == 0 && bit_count == 0)
      else stop_with_failure($sformatf("chip enable went low in %0s, which expects no command",
                                       vec_name[idx]));
   endtask

   task automatic run_vector(input int idx);
      string kind;
      int    offs;
      kind = vec_kind[idx];
      offs = 0;
      while (!xfer_ready)
         @(negedge mem_clk);
      issue_cyc = cycles;
      // First low sample comes two edges after the valid edge
      // The handler adds one more edge
      if (kind == "csr")
         write_csr(vec_f1[idx], vec_f2[idx]);
      else if (kind == "xfer")
      begin
         pulse_xfer(vec_f1[idx][0], vec_f2[idx][1:0], vec_f3[idx][1:0]);
         offs = 3;
      end
      else if (kind == "dpd")
      begin
         // Field 1 adds a global reset request in the same cycle
         pulse_special(1'b1, 1'b0, vec_f1[idx][0]);
         offs = 4;
      end
      else if (kind == "hs")
      begin
         pulse_special(1'b0, 1'b1, 1'b0);
         offs = 4;
      end
      else if (kind == "gr")
      begin
         pulse_special(1'b0, 1'b0, 1'b1);
         offs = 4;
      end
      else
      begin
         assert (kind == "next")
         else stop_with_failure($sformatf("unknown operation kind %0s", kind));
         // Eight low cycles, handler pulse on the first idle edge, then load
         issue_cyc = last_start;
         offs      = 10;
      end
      if (vec_has_exp[idx])
         check_frame(idx, offs);
      else
         check_quiet(idx);
      repeat (2) @(negedge mem_clk);
   endtask

   initial
   begin
      xfer_valid = 1'b0;
      xfer_err   = 2'd0;
      xfer_wr_rd = 1'b0;
      xfer_btype = 2'd0;
      dpd_req    = 1'b0;
      hs_req     = 1'b0;
      gr_req     = 1'b0;
      csr_wr_en  = 1'b0;
      csr_addr   = 3'd0;
      csr_wdata  = 8'h00;
      shift_in   = 8'h00;
      load_vectors();
      cycle_limit = 20 * vec_name.size() + 100;
      wait (rst_n == 1'b1);
      @(negedge mem_clk);
      // Ready, chip enable and data pin after reset
      assert (xfer_ready === 1'b1 && mem_ce_n === 1'b1 && mem_dq === 1'b0)
      else stop_with_failure($sformatf("mismatch reset_state expected %03b actual %03b",
                                       3'b110, {xfer_ready, mem_ce_n, mem_dq}));
      for (int i = 0; i < vec_name.size(); i++)
         run_vector(i);
      $display("RESULT: PASS");
      $finish;
   end

endmodule
